//--- logic/pe_pkg.sv
package pe_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    localparam int NUM_LANES  = 4;                     // lanes per word
    localparam int LANE_WIDTH = 8;                     // bits per lane
    localparam int DATA_WIDTH = NUM_LANES * LANE_WIDTH; // 32-bit word
    localparam int INST_WIDTH = 64;
    localparam int LATENCY    = 4;                     // inst_v edge to dout_v

    typedef logic [DATA_WIDTH-1:0] data_t; // four packed lanes
    typedef logic [LANE_WIDTH-1:0] lane_t;
    typedef logic [INST_WIDTH-1:0] inst_t;
    typedef logic [2:0]            opcode_t;

    ////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////
    localparam int SEL_BIT    = 63; // 0 shift (din_pe), 1 write-back (din_wb)
    localparam int OPC_LSB    = 24; // opcode sits in bits 26:24
    localparam int OPC_WIDTH  = 3;
    localparam int IMM_FLAG   = 2;  // top opcode bit marks the I forms

    // opcodes, anything else is a load
    localparam opcode_t OP_ADD  = 3'b001;
    localparam opcode_t OP_SUB  = 3'b010;
    localparam opcode_t OP_MUL  = 3'b011;
    localparam opcode_t OP_ADDI = 3'b101;
    localparam opcode_t OP_SUBI = 3'b110;
    localparam opcode_t OP_MULI = 3'b111;

    ////////////////////////////////////////
    // dsp slice mode fields
    ////////////////////////////////////////
    typedef logic [3:0] alumode_t;
    typedef logic [4:0] inmode_t;
    typedef logic [6:0] opmode_t;

    localparam alumode_t ALU_ADD = 4'b0000; // z + x + y
    localparam alumode_t ALU_SUB = 4'b0011; // z - (x + y)

    localparam inmode_t INM_NONE = 5'b00000; // plain a/b inputs
    localparam inmode_t INM_MUL  = 5'b10001; // registered multiplier inputs

    localparam opmode_t OPM_AB   = 7'b0110011; // a and b into the adder
    localparam opmode_t OPM_MUL  = 7'b0000101; // product out
    localparam opmode_t OPM_ZERO = 7'b0000000; // load, result zero

endpackage

//--- logic/dsp_ctrl_if.sv
`timescale 1ns/1ps

// per-lane slice controls, decoder to lane array
interface dsp_ctrl_if;

    pe_pkg::alumode_t [pe_pkg::NUM_LANES-1:0] alumode; // one field per lane
    pe_pkg::inmode_t  [pe_pkg::NUM_LANES-1:0] inmode;
    pe_pkg::opmode_t  [pe_pkg::NUM_LANES-1:0] opmode;
    logic             [pe_pkg::NUM_LANES-1:0] usemult; // multiplier in use
    logic                                     valid;   // arithmetic op accepted

    // decoder side
    modport decode (
        output alumode,
        output inmode,
        output opmode,
        output usemult,
        output valid
    );

    // lane array side
    modport lane (
        input alumode,
        input inmode,
        input opmode,
        input usemult,
        input valid
    );

endinterface

//--- logic/pe_decode.sv
`timescale 1ns/1ps

module pe_decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_v,
    input  pe_pkg::opcode_t   opcode,
    dsp_ctrl_if.decode        ctrl
);

    ////////////////////////////////////////
    // opcode table, one lane's worth
    ////////////////////////////////////////
    pe_pkg::alumode_t alu_n;
    pe_pkg::inmode_t  inm_n;
    pe_pkg::opmode_t  opm_n;
    logic             mul_n;
    logic             arith; // opcode is not a load

    always_comb begin
        // load by default: zero modes, nothing valid
        alu_n = pe_pkg::ALU_ADD;
        inm_n = pe_pkg::INM_NONE;
        opm_n = pe_pkg::OPM_ZERO;
        mul_n = 1'b0;
        arith = 1'b0;
        case (opcode)
            pe_pkg::OP_ADD, pe_pkg::OP_ADDI: begin
                opm_n = pe_pkg::OPM_AB;   // a + b
                arith = 1'b1;
            end
            pe_pkg::OP_SUB, pe_pkg::OP_SUBI: begin
                alu_n = pe_pkg::ALU_SUB;  // a - b
                opm_n = pe_pkg::OPM_AB;
                arith = 1'b1;
            end
            pe_pkg::OP_MUL, pe_pkg::OP_MULI: begin
                inm_n = pe_pkg::INM_MUL;  // multiplier path
                opm_n = pe_pkg::OPM_MUL;
                mul_n = 1'b1;
                arith = 1'b1;
            end
            default: begin
                arith = 1'b0;             // 000 / 100 are loads
            end
        endcase
    end

    ////////////////////////////////////////
    // edge 1, register controls for all lanes
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.alumode <= '0;
            ctrl.inmode  <= '0;
            ctrl.opmode  <= '0;
            ctrl.usemult <= '0;
            ctrl.valid   <= 1'b0;
        end else begin
            // same pattern copied to every lane
            ctrl.alumode <= {pe_pkg::NUM_LANES{alu_n}};
            ctrl.inmode  <= {pe_pkg::NUM_LANES{inm_n}};
            ctrl.opmode  <= {pe_pkg::NUM_LANES{opm_n}};
            ctrl.usemult <= {pe_pkg::NUM_LANES{mul_n}};
            ctrl.valid   <= inst_v & arith; // only strobed arithmetic ops
        end
    end

endmodule

//--- logic/operand_path.sv
`timescale 1ns/1ps

module operand_path (
    input  logic            clk,
    input  logic            inst_v,
    input  pe_pkg::inst_t   inst,
    input  pe_pkg::data_t   din_pe,
    input  pe_pkg::data_t   din_wb,
    input  pe_pkg::data_t   din_b,
    output pe_pkg::data_t   opa,
    output pe_pkg::data_t   opb
);

    ////////////////////////////////////////
    // operand a select
    ////////////////////////////////////////
    logic          sel;   // 1 picks write-back word
    pe_pkg::data_t a_nxt;

    assign sel   = inst_v & inst[pe_pkg::SEL_BIT];
    assign a_nxt = sel ? din_wb : din_pe; // shift data when idle

    ////////////////////////////////////////
    // operand b select
    ////////////////////////////////////////
    logic          imm_form; // ADDI / SUBI / MULI
    pe_pkg::lane_t imm;
    pe_pkg::data_t imm_word;
    pe_pkg::data_t b_nxt;

    assign imm_form = inst[pe_pkg::OPC_LSB + pe_pkg::IMM_FLAG];
    assign imm      = inst[pe_pkg::LANE_WIDTH-1:0];         // low byte
    assign imm_word = {pe_pkg::NUM_LANES{imm}};             // broadcast to lanes
    assign b_nxt    = imm_form ? imm_word : din_b;

    // edge 1, operands land alongside the decoded controls
    always_ff @(posedge clk) begin
        opa <= a_nxt;
        opb <= b_nxt;
    end

endmodule

//--- logic/dsp_lane_array.sv
`timescale 1ns/1ps

module dsp_lane_array (
    input  logic            clk,
    input  logic            rst,
    dsp_ctrl_if.lane        ctrl,
    input  pe_pkg::data_t   opa,
    input  pe_pkg::data_t   opb,
    output pe_pkg::data_t   dout,
    output logic            dout_v
);

    localparam int W = pe_pkg::LANE_WIDTH;

    pe_pkg::lane_t out_q [pe_pkg::NUM_LANES]; // per-lane output register

    ////////////////////////////////////////
    // lanes
    ////////////////////////////////////////
    for (genvar i = 0; i < pe_pkg::NUM_LANES; i++) begin : g_lane
        pe_pkg::lane_t    a_r;        // stage 2 input regs
        pe_pkg::lane_t    b_r;
        pe_pkg::alumode_t alumode_r;
        pe_pkg::inmode_t  inmode_r;
        pe_pkg::opmode_t  opmode_r;
        logic             usemult_r;
        logic [2*W-1:0]   prod;       // full product, low byte kept
        pe_pkg::lane_t    res;
        pe_pkg::lane_t    p_r;        // stage 3 result reg

        // edge 2, lane slice and its controls
        always_ff @(posedge clk) begin
            a_r       <= opa[i*W +: W];
            b_r       <= opb[i*W +: W];
            alumode_r <= ctrl.alumode[i];
            inmode_r  <= ctrl.inmode[i];
            opmode_r  <= ctrl.opmode[i];
            usemult_r <= ctrl.usemult[i];
        end

        assign prod = a_r * b_r;

        always_comb begin
            if (usemult_r && inmode_r == pe_pkg::INM_MUL && opmode_r == pe_pkg::OPM_MUL) begin
                res = prod[W-1:0];                // mod 256
            end else if (opmode_r == pe_pkg::OPM_AB) begin
                // wraps inside the lane, no carry out
                res = (alumode_r == pe_pkg::ALU_SUB) ? a_r - b_r : a_r + b_r;
            end else begin
                res = '0;                         // zero opmode
            end
        end

        // edge 3 result, edge 4 output
        always_ff @(posedge clk) begin
            p_r      <= res;
            out_q[i] <= p_r;
        end
    end

    // repack lanes into the word
    always_comb begin
        for (int k = 0; k < pe_pkg::NUM_LANES; k++) begin
            dout[k*W +: W] = out_q[k];
        end
    end

    ////////////////////////////////////////
    // valid delay line, edges 2..4
    ////////////////////////////////////////
    logic [pe_pkg::LATENCY-2:0] v_pipe;

    always_ff @(posedge clk) begin
        if (rst) begin
            v_pipe <= '0;
        end else begin
            v_pipe <= {v_pipe[pe_pkg::LATENCY-3:0], ctrl.valid};
        end
    end

    assign dout_v = v_pipe[pe_pkg::LATENCY-2]; // lines up with out_q

endmodule

//--- logic/pe_top.sv
`timescale 1ns/1ps

module pe_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_v,
    input  pe_pkg::inst_t   inst,
    input  pe_pkg::data_t   din_pe,
    input  pe_pkg::data_t   din_wb,
    input  pe_pkg::data_t   din_b,
    output pe_pkg::data_t   dout,
    output logic            dout_v
);

    ////////////////////////////////////////
    // internal wiring
    ////////////////////////////////////////
    dsp_ctrl_if    ctrl ();     // decoded slice controls
    pe_pkg::data_t opa;         // registered operand a
    pe_pkg::data_t opb;         // registered operand b

    // decoder, edge 1
    pe_decode u_decode (
        .clk    (clk),
        .rst    (rst),
        .inst_v (inst_v),
        .opcode (inst[pe_pkg::OPC_LSB +: pe_pkg::OPC_WIDTH]), // bits 26:24
        .ctrl   (ctrl.decode)
    );

    // operand select, also edge 1
    operand_path u_operands (
        .clk    (clk),
        .inst_v (inst_v),
        .inst   (inst),
        .din_pe (din_pe),
        .din_wb (din_wb),
        .din_b  (din_b),
        .opa    (opa),
        .opb    (opb)
    );

    // lanes, edges 2..4
    dsp_lane_array u_lanes (
        .clk    (clk),
        .rst    (rst),
        .ctrl   (ctrl.lane),
        .opa    (opa),
        .opb    (opb),
        .dout   (dout),
        .dout_v (dout_v)
    );

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

// free running clock plus power-on reset
module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk); // three reset cycles
        @(negedge clk);
        rst = 1'b0;                // released on a falling edge
    end

endmodule

//--- testbench/pe_props.sv
`timescale 1ns/1ps

// bound into pe_top, reference model built from delayed inputs
module pe_props (
    input logic          clk,
    input logic          rst,
    input logic          inst_v,
    input pe_pkg::inst_t inst,
    input pe_pkg::data_t din_pe,
    input pe_pkg::data_t din_wb,
    input pe_pkg::data_t din_b,
    input pe_pkg::data_t dout,
    input logic          dout_v
);

    int            fail_count = 0; // read by the testbench
    int unsigned   since_rst  = 0; // cycles since reset dropped
    logic          warm;           // enough history for $past
    logic          exp_v;
    pe_pkg::data_t exp_word;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    function automatic pe_pkg::data_t lane_math(input pe_pkg::inst_t i,
            input pe_pkg::data_t pe, input pe_pkg::data_t wb, input pe_pkg::data_t b);
        pe_pkg::opcode_t op;
        pe_pkg::data_t   a_w;
        pe_pkg::data_t   b_w;
        pe_pkg::data_t   r;
        pe_pkg::lane_t   x;
        pe_pkg::lane_t   y;
        op  = i[pe_pkg::OPC_LSB +: pe_pkg::OPC_WIDTH];
        a_w = i[pe_pkg::SEL_BIT] ? wb : pe;                // write-back or shift word
        b_w = op[pe_pkg::IMM_FLAG] ? {4{i[7:0]}} : b;      // immediate in every lane
        r   = '0;
        for (int k = 0; k < pe_pkg::NUM_LANES; k++) begin
            x = a_w[k*8 +: 8];
            y = b_w[k*8 +: 8];
            case (op)
                pe_pkg::OP_ADD, pe_pkg::OP_ADDI: r[k*8 +: 8] = x + y; // mod 256
                pe_pkg::OP_SUB, pe_pkg::OP_SUBI: r[k*8 +: 8] = x - y;
                pe_pkg::OP_MUL, pe_pkg::OP_MULI: r[k*8 +: 8] = x * y; // low byte
                default:                          r[k*8 +: 8] = '0;
            endcase
        end
        return r;
    endfunction

    assign exp_v    = inst_v && (inst[pe_pkg::OPC_LSB +: 2] != 2'b00); // 000/100 load
    assign exp_word = lane_math(inst, din_pe, din_wb, din_b);

    always @(posedge clk) begin
        if (rst) begin
            since_rst <= 0;
        end else if (since_rst < pe_pkg::LATENCY) begin
            since_rst <= since_rst + 1;
        end
    end

    assign warm = (since_rst >= pe_pkg::LATENCY);

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !warm |-> !dout_v)
        else begin fail_count++; $error("dout_v rose before the pipeline filled"); end

    a_valid_timing: assert property (@(posedge clk) disable iff (rst)
        warm |-> dout_v == $past(exp_v, pe_pkg::LATENCY))
        else begin fail_count++; $error("dout_v does not match the instruction stream"); end

    a_result: assert property (@(posedge clk) disable iff (rst)
        warm && dout_v |-> dout == $past(exp_word, pe_pkg::LATENCY))
        else begin fail_count++; $error("dout lane result mismatch"); end

endmodule

//--- testbench/pe_tb.sv
`timescale 1ns/1ps

module pe_tb;

    localparam int WAIT_LIMIT = 40; // cycles per pulse wait

    logic          clk;
    logic          rst;
    logic          inst_v;
    pe_pkg::inst_t inst;
    pe_pkg::data_t din_pe;
    pe_pkg::data_t din_wb;
    pe_pkg::data_t din_b;
    pe_pkg::data_t dout;
    logic          dout_v;

    integer seed;
    int     pulses   = 0; // dout_v pulses seen so far
    int     errors   = 0;
    int     timeouts = 0;
    int     tests    = 0;
    int     start_pulses;
    int     start_afail;
    int     want;
    pe_pkg::opcode_t op;

    tb_clock u_clock (.clk(clk), .rst(rst));

    pe_top dut (.*);

    bind pe_top pe_props u_props (.*);

    always @(posedge clk) begin
        if (!rst && dout_v) pulses <= pulses + 1; // sampled like a flop
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic send(input pe_pkg::opcode_t opc, input logic sel,
            input pe_pkg::data_t pe, input pe_pkg::data_t wb, input pe_pkg::data_t b);
        pe_pkg::inst_t w;
        w[63:32] = $random(seed);
        w[31:0]  = $random(seed);                   // random low byte = immediate
        w[pe_pkg::SEL_BIT] = sel;
        w[pe_pkg::OPC_LSB +: pe_pkg::OPC_WIDTH] = opc;
        @(negedge clk);
        inst_v = 1'b1;
        inst   = w;
        din_pe = pe;
        din_wb = wb;
        din_b  = b;
    endtask

    task automatic send_rand(input pe_pkg::opcode_t opc, input logic sel);
        send(opc, sel, $random(seed), $random(seed), $random(seed));
    endtask

    // strobe low, random garbage on the buses
    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            inst_v = 1'b0;
            inst   = {$random(seed), $random(seed)};
            din_pe = $random(seed);
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            timeouts++;
            $display("Reset was never released, the wait timed out.");
        end
    endtask

    task automatic begin_test();
        start_pulses = pulses;
        start_afail  = dut.u_props.fail_count;
    endtask

    task automatic end_test(input string name, input int n_want);
        int waited;
        int got;
        int af;
        @(negedge clk);
        inst_v = 1'b0;
        waited = 0;
        while (pulses - start_pulses < n_want && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (pulses - start_pulses < n_want) begin
            timeouts++;
            tests++;
            $display("Test %s: the wait for dout_v pulses timed out after %0d cycles.",
                     name, waited);
        end else begin
            repeat (pe_pkg::LATENCY + 1) @(negedge clk); // late or extra pulses land here
            got = pulses - start_pulses;
            af  = dut.u_props.fail_count - start_afail;
            tests++;
            if (got != n_want) begin
                errors++;
                $display("** Error at %0t: test %s got %0d dout_v pulses, expected %0d",
                         $time, name, got, n_want);
            end
            $display("test %0d %-12s pulses %0d/%0d, assertion failures %0d",
                     tests, name, got, n_want, af);
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        seed   = 32'hc6ebf938;
        inst_v = 1'b0;
        inst   = '0;
        din_pe = '0;
        din_wb = '0;
        din_b  = '0;
        wait_reset_release();

        begin_test();
        idle(10);                                    // arith codes, strobe low
        end_test("reset_idle", 0);

        begin_test();
        send(pe_pkg::OP_ADD, 1'b0, 32'hff807f01, 32'h0, 32'h018081ff); // every lane wraps
        send(pe_pkg::OP_SUB, 1'b0, 32'h00000000, 32'h0, 32'h01010101); // borrow per lane
        repeat (6) send_rand(pe_pkg::OP_ADD, 1'b0);
        repeat (6) send_rand(pe_pkg::OP_SUB, 1'b0);
        end_test("add_sub", 14);

        begin_test();
        send(pe_pkg::OP_MUL, 1'b0, 32'hff10807f, 32'h0, 32'hff1002ff);
        repeat (7) send_rand(pe_pkg::OP_MUL, 1'b0);
        end_test("mul", 8);

        begin_test();
        repeat (4) send_rand(pe_pkg::OP_ADDI, 1'b0);
        repeat (4) send_rand(pe_pkg::OP_SUBI, 1'b0);
        repeat (4) send_rand(pe_pkg::OP_MULI, 1'b0);
        end_test("immediate", 12);

        begin_test();
        repeat (4) send_rand(pe_pkg::OP_ADD, 1'b1);  // write-back word
        repeat (4) send_rand(pe_pkg::OP_MUL, 1'b1);
        repeat (4) send_rand(pe_pkg::OP_SUBI, 1'b0); // shift word
        end_test("select", 12);

        begin_test();
        repeat (4) send_rand(3'b000, 1'b0);          // loads, no output
        repeat (4) send_rand(3'b100, 1'b1);
        end_test("load", 0);

        begin_test();
        want = 0;
        repeat (40) begin
            op = pe_pkg::opcode_t'($random(seed));
            if (op[1:0] != 2'b00) want++;
            send_rand(op, 1'($random(seed)));
        end
        end_test("back_to_back", want);

        $display("tests %0d, count errors %0d, timeouts %0d, assertion failures %0d",
                 tests, errors, timeouts, dut.u_props.fail_count);
        if (errors == 0 && timeouts == 0 && dut.u_props.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sim.f
logic/pe_pkg.sv
logic/dsp_ctrl_if.sv
logic/pe_decode.sv
logic/operand_path.sv
logic/dsp_lane_array.sv
logic/pe_top.sv
testbench/tb_clock.sv
testbench/pe_props.sv
testbench/pe_tb.sv
